//--- source/core_infra_pkg.sv
//////////////////////////////
// Shared widths, cache geometry and types for the core infrastructure.
// Import into module headers with a wildcard import.
//////////////////////////////

package core_infra_pkg;

  // Register file
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Instruction cache geometry
  localparam int unsigned IC_NUM_WAYS  = 2;
  localparam int unsigned IC_NUM_LINES = 64;
  localparam int unsigned IC_INDEX_W   = 6;
  localparam int unsigned IC_TAG_W     = 22;
  localparam int unsigned IC_LINE_W    = 64;

  // Scrambling
  localparam int unsigned SCRAMBLE_KEY_W   = 128;
  localparam int unsigned SCRAMBLE_NONCE_W = 64;

  localparam logic [SCRAMBLE_KEY_W-1:0] RST_SCR_KEY =
      128'h3b8f_21c4_9d07_e6a5_5c12_f0b3_8e49_d7a6;
  localparam logic [SCRAMBLE_NONCE_W-1:0] RST_SCR_NONCE = 64'h91e4_2d7c_06ab_f358;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [REG_ADDR_W-1:0]       reg_addr_t;
  typedef logic [IC_INDEX_W-1:0]       ic_index_t;
  typedef logic [IC_TAG_W-1:0]         ic_tag_t;
  typedef logic [IC_LINE_W-1:0]        ic_line_t;
  typedef logic [IC_NUM_WAYS-1:0]      ic_way_mask_t;
  typedef logic [SCRAMBLE_KEY_W-1:0]   scr_key_t;
  typedef logic [SCRAMBLE_NONCE_W-1:0] scr_nonce_t;

  // Key request FSM
  typedef enum logic {
    SCR_IDLE = 1'b0,
    SCR_REQ  = 1'b1
  } scr_state_e;

endpackage

//--- source/ic_ram_if.sv
//////////////////////////////
// Tag and data RAM request bundle, shared by all cache ways.
// Each way picks its own bit out of the request masks.
//////////////////////////////

`timescale 1ns/1ps

interface ic_ram_if import core_infra_pkg::*; ();

  ic_way_mask_t tag_req;
  logic         tag_write;
  ic_index_t    tag_addr;
  ic_tag_t      tag_wdata;
  ic_way_mask_t data_req;
  logic         data_write;
  ic_index_t    data_addr;
  ic_line_t     data_wdata;

  modport ctrl (
    output tag_req, tag_write, tag_addr, tag_wdata,
    output data_req, data_write, data_addr, data_wdata
  );

  modport ram (
    input tag_req, tag_write, tag_addr, tag_wdata,
    input data_req, data_write, data_addr, data_wdata
  );

endinterface

//--- source/register_file.sv
//////////////////////////////
// General purpose registers x1..x31 with two combinational read
// ports and one write port. x0 reads as zero.
//////////////////////////////

`timescale 1ns/1ps

module register_file import core_infra_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  // No storage behind x0
  word_t rf_q [1:2**REG_ADDR_W-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 2**REG_ADDR_W; i++) begin
        rf_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      rf_q[waddr_i] <= wdata_i;
    end
  end

  // Read ports
  always_comb begin
    rdata_a_o = '0;
    if (raddr_a_i != '0) begin
      rdata_a_o = rf_q[raddr_a_i];
    end
  end

  always_comb begin
    rdata_b_o = '0;
    if (raddr_b_i != '0) begin
      rdata_b_o = rf_q[raddr_b_i];
    end
  end

endmodule

//--- source/icache_scr_bank.sv
//////////////////////////////
// One instruction cache way: a tag bank and a data bank, both
// single port with a registered read, XOR scrambled with the key.
//////////////////////////////

`timescale 1ns/1ps

module icache_scr_bank import core_infra_pkg::*; #(
  parameter int unsigned WAY = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  ic_ram_if.ram      ram,
  input  scr_key_t   key_i,
  input  scr_nonce_t nonce_i,
  output ic_tag_t    tag_rdata_o,
  output ic_line_t   data_rdata_o
);

  ic_tag_t  tag_mem  [IC_NUM_LINES];
  ic_line_t data_mem [IC_NUM_LINES];

  ic_tag_t  tag_mask;
  ic_line_t data_mask;
  ic_tag_t  tag_rdata_q;
  ic_line_t data_rdata_q;

  // Masks from the current key
  assign tag_mask  = key_i[SCRAMBLE_KEY_W-1 -: IC_TAG_W];
  assign data_mask = key_i[IC_LINE_W-1:0] ^ nonce_i;

  ////////////////////////////
  // RAM arrays
  ////////////////////////////

  always_ff @(posedge clk_i) begin
    if (ram.tag_req[WAY] && ram.tag_write) begin
      tag_mem[ram.tag_addr] <= ram.tag_wdata ^ tag_mask;
    end
    if (ram.data_req[WAY] && ram.data_write) begin
      data_mem[ram.data_addr] <= ram.data_wdata ^ data_mask;
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_rdata_q  <= '0;
      data_rdata_q <= '0;
    end else begin
      if (ram.tag_req[WAY] && !ram.tag_write) begin
        tag_rdata_q <= tag_mem[ram.tag_addr] ^ tag_mask;
      end
      if (ram.data_req[WAY] && !ram.data_write) begin
        data_rdata_q <= data_mem[ram.data_addr] ^ data_mask;
      end
    end
  end

  assign tag_rdata_o  = tag_rdata_q;
  assign data_rdata_o = data_rdata_q;

endmodule

//--- source/scramble_key_ctrl.sv
//////////////////////////////
// Scramble key and nonce registers plus the request/valid handshake
// with the key provider. An invalidate asks for a fresh key.
//////////////////////////////

`timescale 1ns/1ps

module scramble_key_ctrl import core_infra_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       icache_inval_i,
  input  logic       scramble_key_valid_i,
  input  scr_key_t   scramble_key_i,
  input  scr_nonce_t scramble_nonce_i,
  output logic       scramble_req_o,
  output logic       key_valid_o,
  output scr_key_t   key_o,
  output scr_nonce_t nonce_o
);

  scr_state_e state_q, state_d;
  logic       key_valid_q, key_valid_d;

  // Request held until the provider returns a key
  always_comb begin
    state_d     = state_q;
    key_valid_d = key_valid_q;
    unique case (state_q)
      SCR_IDLE: begin
        if (icache_inval_i) begin
          state_d     = SCR_REQ;
          key_valid_d = 1'b0;
        end
      end
      SCR_REQ: begin
        if (scramble_key_valid_i) begin
          state_d     = SCR_IDLE;
          key_valid_d = 1'b1;
        end
      end
      default: state_d = SCR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SCR_IDLE;
      key_valid_q <= 1'b1;
      key_o       <= RST_SCR_KEY;
      nonce_o     <= RST_SCR_NONCE;
    end else begin
      state_q     <= state_d;
      key_valid_q <= key_valid_d;
      if (scramble_key_valid_i) begin
        key_o   <= scramble_key_i;
        nonce_o <= scramble_nonce_i;
      end
    end
  end

  assign scramble_req_o = (state_q == SCR_REQ);
  assign key_valid_o    = key_valid_q;

endmodule

//--- source/core_infra_top.sv
//////////////////////////////
// Core infrastructure top level: sleep status, register file,
// scrambled instruction cache RAMs and the key handshake.
// The pipeline side of every connection comes in as plain ports.
//////////////////////////////

`timescale 1ns/1ps

module core_infra_top import core_infra_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         core_busy_i,
  input  logic         debug_req_i,
  input  logic         irq_pending_i,
  input  logic         irq_nm_i,
  output logic         core_sleep_o,

  // Register file
  input  reg_addr_t    rf_raddr_a_i,
  input  reg_addr_t    rf_raddr_b_i,
  input  reg_addr_t    rf_waddr_i,
  input  word_t        rf_wdata_i,
  input  logic         rf_we_i,
  output word_t        rf_rdata_a_o,
  output word_t        rf_rdata_b_o,

  // Tag RAM
  input  ic_way_mask_t ic_tag_req_i,
  input  logic         ic_tag_write_i,
  input  ic_index_t    ic_tag_addr_i,
  input  ic_tag_t      ic_tag_wdata_i,
  output ic_tag_t      ic_tag_rdata_o [IC_NUM_WAYS],

  // Data RAM
  input  ic_way_mask_t ic_data_req_i,
  input  logic         ic_data_write_i,
  input  ic_index_t    ic_data_addr_i,
  input  ic_line_t     ic_data_wdata_i,
  output ic_line_t     ic_data_rdata_o [IC_NUM_WAYS],

  // Scramble key provider
  input  logic         icache_inval_i,
  input  logic         scramble_key_valid_i,
  input  scr_key_t     scramble_key_i,
  input  scr_nonce_t   scramble_nonce_i,
  output logic         scramble_req_o,
  output logic         scr_key_valid_o
);

  logic       core_busy_q;
  scr_key_t   scr_key;
  scr_nonce_t scr_nonce;

  ////////////////////////////
  // Sleep status
  ////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake sources other than busy act at once
  assign core_sleep_o = ~(core_busy_q | debug_req_i | irq_pending_i | irq_nm_i);

  ////////////////////////////
  // Register file
  ////////////////////////////

  register_file u_register_file (
    .clk_i,
    .rst_ni,
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o)
  );

  ////////////////////////////
  // Scramble key
  ////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i,
    .rst_ni,
    .icache_inval_i,
    .scramble_key_valid_i,
    .scramble_key_i,
    .scramble_nonce_i,
    .scramble_req_o,
    .key_valid_o(scr_key_valid_o),
    .key_o      (scr_key),
    .nonce_o    (scr_nonce)
  );

  ////////////////////////////
  // Cache RAMs
  ////////////////////////////

  ic_ram_if ic_ram ();

  assign ic_ram.tag_req    = ic_tag_req_i;
  assign ic_ram.tag_write  = ic_tag_write_i;
  assign ic_ram.tag_addr   = ic_tag_addr_i;
  assign ic_ram.tag_wdata  = ic_tag_wdata_i;
  assign ic_ram.data_req   = ic_data_req_i;
  assign ic_ram.data_write = ic_data_write_i;
  assign ic_ram.data_addr  = ic_data_addr_i;
  assign ic_ram.data_wdata = ic_data_wdata_i;

  // One bank pair per way, all sharing the same request bundle
  for (genvar w = 0; w < IC_NUM_WAYS; w++) begin : gen_ways
    icache_scr_bank #(
      .WAY(w)
    ) u_bank (
      .clk_i,
      .rst_ni,
      .ram         (ic_ram.ram),
      .key_i       (scr_key),
      .nonce_i     (scr_nonce),
      .tag_rdata_o (ic_tag_rdata_o[w]),
      .data_rdata_o(ic_data_rdata_o[w])
    );
  end

endmodule

//--- testbench/tb_core_infra.sv
//////////////////////////////
// Testbench for core_infra_top covering sleep status, the register
// file, the scrambled cache ways and the rekey handshake.
// Run through the Makefile test target.
//////////////////////////////

`timescale 1ns/1ps

module tb_core_infra import core_infra_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int SLEEP_CYCLES = 200;
  localparam int RF_OPS       = 300;
  localparam int KEY_WAIT_MAX = 16;
  localparam int TEST_CYCLES  = RESET_CYCLES + SLEEP_CYCLES + RF_OPS + KEY_WAIT_MAX + 60;

  typedef logic [$clog2(IC_NUM_WAYS)-1:0] way_t;

  logic clk_i = 1'b0;
  logic rst_ni, core_busy_i, debug_req_i, irq_pending_i, irq_nm_i, core_sleep_o;
  reg_addr_t rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  word_t rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  logic rf_we_i;
  ic_way_mask_t ic_tag_req_i, ic_data_req_i;
  logic ic_tag_write_i, ic_data_write_i;
  ic_index_t ic_tag_addr_i, ic_data_addr_i;
  ic_tag_t ic_tag_wdata_i;
  ic_line_t ic_data_wdata_i;
  ic_tag_t ic_tag_rdata_o [IC_NUM_WAYS];
  ic_line_t ic_data_rdata_o [IC_NUM_WAYS];
  logic icache_inval_i, scramble_key_valid_i, scramble_req_o, scr_key_valid_o;
  scr_key_t scramble_key_i;
  scr_nonce_t scramble_nonce_i;

  // Reference models
  integer     seed = 32'h08f6209a;
  logic       checks_on = 1'b0;
  logic       post_reset_chk = 1'b0;
  logic       busy_d, exp_sleep;
  word_t      rf_model [2**REG_ADDR_W];
  word_t      exp_rf_a, exp_rf_b;
  ic_tag_t    tag_store [IC_NUM_WAYS][IC_NUM_LINES];
  ic_line_t   data_store [IC_NUM_WAYS][IC_NUM_LINES];
  ic_tag_t    exp_tag [IC_NUM_WAYS];
  ic_line_t   exp_data [IC_NUM_WAYS];
  scr_key_t   cur_key = RST_SCR_KEY;
  scr_nonce_t cur_nonce = RST_SCR_NONCE;

  core_infra_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic ic_tag_t tag_mask(input scr_key_t key);
    return key[SCRAMBLE_KEY_W-1 -: IC_TAG_W];
  endfunction

  function automatic ic_line_t data_mask(input scr_key_t key, input scr_nonce_t nonce);
    return key[IC_LINE_W-1:0] ^ nonce;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // Busy counts one cycle late
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_d <= 1'b0;
    end else begin
      busy_d <= core_busy_i;
    end
  end
  assign exp_sleep = !(busy_d || debug_req_i || irq_pending_i || irq_nm_i);

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge clk_i) disable iff (!checks_on) core_sleep_o == exp_sleep)
    else report_fail($sformatf("Fail core_sleep_o: got %h expected %h",
                               $sampled(core_sleep_o), $sampled(exp_sleep)));
  assert property (@(posedge clk_i) disable iff (!checks_on) rf_rdata_a_o == exp_rf_a)
    else report_fail($sformatf("Fail rf_rdata_a_o: got %h expected %h",
                               $sampled(rf_rdata_a_o), $sampled(exp_rf_a)));
  assert property (@(posedge clk_i) disable iff (!checks_on) rf_rdata_b_o == exp_rf_b)
    else report_fail($sformatf("Fail rf_rdata_b_o: got %h expected %h",
                               $sampled(rf_rdata_b_o), $sampled(exp_rf_b)));
  assert property (@(posedge clk_i) disable iff (!checks_on) post_reset_chk |-> !scramble_req_o)
    else report_fail($sformatf("Fail scramble_req_o: got %h expected 0",
                               $sampled(scramble_req_o)));
  assert property (@(posedge clk_i) disable iff (!checks_on)
                   scr_key_valid_o == !scramble_req_o)
    else report_fail($sformatf("Fail scr_key_valid_o: got %h expected %h",
                               $sampled(scr_key_valid_o), !$sampled(scramble_req_o)));
  assert property (@(posedge clk_i) disable iff (!checks_on)
                   icache_inval_i && !scramble_req_o |=> scramble_req_o)
    else report_fail("Fail scramble_req_o: got 0 expected 1 after invalidate");
  assert property (@(posedge clk_i) disable iff (!checks_on)
                   scramble_req_o && !scramble_key_valid_i |=> scramble_req_o)
    else report_fail("Fail scramble_req_o: got 0 expected 1 while waiting for a key");
  assert property (@(posedge clk_i) disable iff (!checks_on)
                   scramble_req_o && scramble_key_valid_i |=> !scramble_req_o)
    else report_fail("Fail scramble_req_o: got 1 expected 0 after key delivery");

  for (genvar w = 0; w < IC_NUM_WAYS; w++) begin : gen_way_chk
    assert property (@(posedge clk_i) disable iff (!checks_on) ic_tag_rdata_o[w] == exp_tag[w])
      else report_fail($sformatf("Fail ic_tag_rdata_o[%0d]: got %h expected %h", w,
                                 $sampled(ic_tag_rdata_o[w]), $sampled(exp_tag[w])));
    assert property (@(posedge clk_i) disable iff (!checks_on)
                     ic_data_rdata_o[w] == exp_data[w])
      else report_fail($sformatf("Fail ic_data_rdata_o[%0d]: got %h expected %h", w,
                                 $sampled(ic_data_rdata_o[w]), $sampled(exp_data[w])));
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Reads see the array before this cycle's write
  task automatic rf_step(input reg_addr_t ra, input reg_addr_t rb, input reg_addr_t wa,
                         input word_t wd, input logic we);
    rf_raddr_a_i = ra;
    rf_raddr_b_i = rb;
    rf_waddr_i   = wa;
    rf_wdata_i   = wd;
    rf_we_i      = we;
    exp_rf_a     = rf_model[ra];
    exp_rf_b     = rf_model[rb];
    if (we && wa != '0) begin
      rf_model[wa] = wd;
    end
    @(negedge clk_i);
  endtask

  task automatic cache_access(input way_t w, input ic_index_t idx, input logic wr,
                              input ic_tag_t tg, input ic_line_t ln);
    ic_tag_req_i    = ic_way_mask_t'(1) << w;
    ic_data_req_i   = ic_way_mask_t'(1) << w;
    ic_tag_write_i  = wr;
    ic_data_write_i = wr;
    ic_tag_addr_i   = idx;
    ic_data_addr_i  = idx;
    ic_tag_wdata_i  = tg;
    ic_data_wdata_i = ln;
    if (wr) begin
      tag_store[w][idx]  = tg ^ tag_mask(cur_key);
      data_store[w][idx] = ln ^ data_mask(cur_key, cur_nonce);
    end
    @(negedge clk_i);
    ic_tag_req_i  = '0;
    ic_data_req_i = '0;
    if (!wr) begin
      exp_tag[w]  = tag_store[w][idx] ^ tag_mask(cur_key);
      exp_data[w] = data_store[w][idx] ^ data_mask(cur_key, cur_nonce);
    end
  endtask

  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 2);
    report_fail("Timeout: the test sequence did not finish in time");
  end

  initial begin
    logic [31:0] rnd;
    word_t       wd;
    ic_index_t   idx;
    scr_key_t    new_key;
    int          key_wait;
    rst_ni = 1'b0;
    {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;
    {rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i, rf_wdata_i, rf_we_i} = '0;
    {ic_tag_req_i, ic_tag_write_i, ic_tag_addr_i, ic_tag_wdata_i} = '0;
    {ic_data_req_i, ic_data_write_i, ic_data_addr_i, ic_data_wdata_i} = '0;
    {icache_inval_i, scramble_key_valid_i, scramble_key_i, scramble_nonce_i} = '0;
    exp_rf_a = '0;
    exp_rf_b = '0;
    for (int i = 0; i < 2**REG_ADDR_W; i++) begin
      rf_model[i] = '0;
    end
    for (int i = 0; i < IC_NUM_WAYS; i++) begin
      exp_tag[i]  = '0;
      exp_data[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni         = 1'b1;
    checks_on      = 1'b1;
    post_reset_chk = 1'b1;
    repeat (4) @(negedge clk_i);
    post_reset_chk = 1'b0;

    // Sleep with rare wake sources
    for (int i = 0; i < SLEEP_CYCLES; i++) begin
      rnd           = $random(seed);
      core_busy_i   = rnd[0] & rnd[1];
      debug_req_i   = rnd[2] & rnd[3] & rnd[4];
      irq_pending_i = rnd[5] & rnd[6] & rnd[7];
      irq_nm_i      = rnd[8] & rnd[9] & rnd[10];
      @(negedge clk_i);
    end
    {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;

    // Write to x0 and read it back on both ports
    rf_step('0, '0, '0, 32'hffff_ffff, 1'b1);
    rf_step('0, '0, '0, '0, 1'b0);
    for (int i = 0; i < RF_OPS; i++) begin
      rnd = $random(seed);
      wd  = $random(seed);
      rf_step(rnd[4:0], rnd[9:5], rnd[14:10], wd, rnd[15]);
    end
    rf_step('0, '0, '0, '0, 1'b0);

    // Same line in every way, then reread each way
    rnd = $random(seed);
    idx = rnd[IC_INDEX_W-1:0];
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      rnd = $random(seed);
      cache_access(way_t'(w), idx, 1'b1, rnd[IC_TAG_W-1:0], {$random(seed), $random(seed)});
      cache_access(way_t'(w), idx, 1'b0, '0, '0);
      repeat (3) @(negedge clk_i);
    end
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      cache_access(way_t'(w), idx, 1'b0, '0, '0);
    end

    // Rekey after an invalidate
    icache_inval_i = 1'b1;
    @(negedge clk_i);
    icache_inval_i = 1'b0;
    while (!scramble_req_o) @(negedge clk_i);
    rnd      = $random(seed);
    key_wait = 1 + int'(rnd[3:0]);
    repeat (key_wait) @(negedge clk_i);
    new_key              = {$random(seed), $random(seed), $random(seed), $random(seed)};
    scramble_key_i       = new_key;
    scramble_nonce_i     = {$random(seed), $random(seed)};
    scramble_key_valid_i = 1'b1;
    @(negedge clk_i);
    scramble_key_valid_i = 1'b0;
    cur_key              = new_key;
    cur_nonce            = scramble_nonce_i;
    repeat (2) @(negedge clk_i);

    // Old lines unscramble with the new masks
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      cache_access(way_t'(w), idx, 1'b0, '0, '0);
    end
    rnd = $random(seed);
    cache_access('0, idx + 1'b1, 1'b1, rnd[IC_TAG_W-1:0], {$random(seed), $random(seed)});
    cache_access('0, idx + 1'b1, 1'b0, '0, '0);
    repeat (3) @(negedge clk_i);

    $display("Test passed");
    $finish;
  end

endmodule

//--- build.f
source/core_infra_pkg.sv
source/ic_ram_if.sv
source/register_file.sv
source/icache_scr_bank.sv
source/scramble_key_ctrl.sv
source/core_infra_top.sv
testbench/tb_core_infra.sv

//--- Makefile
# Verilator simulation of the core infrastructure
VERILATOR ?= verilator
TOP       := tb_core_infra
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
